// File: hdl/periph_pkg.sv
/*
 * Shared definitions for the APB peripheral subsystem.
 * The address map, source counts and register indices are fixed here,
 * so no module carries parameters. Each slave decodes a 16-byte window
 * and uses address bits [3:2] as its register index.
 */
package periph_pkg;

	// Bus widths
	localparam int ADDR_W = 12;
	localparam int DATA_W = 32;

	// Each slave window is 16 bytes, so the decode ignores the low 4 bits
	localparam int WIN_BITS = 4;

	localparam logic [ADDR_W-1:0] IRQ_BASE = 12'h000;
	localparam logic [ADDR_W-1:0] TIMER_BASE = 12'h010;

	// Seven external lines plus the timer give eight controller sources
	localparam int NR_EXT_IRQS = 7;
	localparam int NR_IRQS = 8;
	localparam int TMR_IRQ_SRC = 7;

	// Interrupt controller register indices
	localparam logic [1:0] IRQ_STATUS = 2'd0;
	localparam logic [1:0] IRQ_ENABLE = 2'd1;
	localparam logic [1:0] IRQ_DISABLE = 2'd2;
	localparam logic [1:0] IRQ_TEST = 2'd3;

	// Interval timer register indices
	localparam logic [1:0] TMR_CTRL = 2'd0;
	localparam logic [1:0] TMR_LOAD = 2'd1;
	localparam logic [1:0] TMR_COUNT = 2'd2;
	localparam logic [1:0] TMR_EXPIRED = 2'd3;

	// Master-side transfer fields; psel is derived per slave by the fabric
	typedef struct packed {
		logic [ADDR_W-1:0] paddr;
		logic              pwrite;
		logic [DATA_W-1:0] pwdata;
		logic              penable;
	} apb_req_t;

	// Slave-side response fields
	typedef struct packed {
		logic [DATA_W-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

endpackage

// File: hdl/apb_fabric.sv
/*
 * APB address decode and response merge for the two slaves.
 * At most one slave select is high at a time. A transfer outside both
 * windows completes in its first access cycle with pslverr high and
 * zero read data. The fabric adds no wait states of its own.
 */
`timescale 1ns/1ps

module apb_fabric (
	input  logic                 psel,
	input  periph_pkg::apb_req_t req,
	input  periph_pkg::apb_rsp_t irq_rsp,
	input  periph_pkg::apb_rsp_t timer_rsp,
	output logic                 irq_sel,
	output logic                 timer_sel,
	output periph_pkg::apb_rsp_t rsp
);

	logic irq_hit;
	logic timer_hit;
	logic unmapped;

	// Decode, select and merge are kept in one block so the checks below
	// always see a consistent set of values
	always_comb begin
		irq_hit = (req.paddr >> periph_pkg::WIN_BITS) ==
			(periph_pkg::IRQ_BASE >> periph_pkg::WIN_BITS);
		timer_hit = (req.paddr >> periph_pkg::WIN_BITS) ==
			(periph_pkg::TIMER_BASE >> periph_pkg::WIN_BITS);

		irq_sel = psel && irq_hit;
		timer_sel = psel && timer_hit;
		unmapped = psel && !irq_hit && !timer_hit;

		// Idle bus and the setup phase of a hole see a zero response
		rsp = '0;
		if (irq_sel) begin
			rsp = irq_rsp;
		end else if (timer_sel) begin
			rsp = timer_rsp;
		end else if (unmapped && req.penable) begin
			rsp.pready = 1'b1;
			rsp.pslverr = 1'b1;
		end

		// Checked whenever the decode inputs and slave acknowledges are known
		if (!$isunknown({psel, req.paddr, irq_rsp.pready, timer_rsp.pready})) begin
			// A slave may only acknowledge while the fabric selects it
			a_ack_selected: assert (!(irq_rsp.pready && !irq_sel) &&
				!(timer_rsp.pready && !timer_sel))
			else
				$error("slave pready without its select at address %h", req.paddr);

			// Slaves never signal an error themselves, so an error must
			// be the fabric's own answer to a hole in the map
			if (rsp.pslverr) begin
				a_err_unmapped: assert (unmapped)
				else
					$error("pslverr returned for mapped address %h", req.paddr);
			end
		end
	end

endmodule

// File: hdl/irq_ctrl.sv
/*
 * Interrupt controller for eight level-sensitive sources.
 * irq_req is high whenever any enabled source is active, where a source
 * is active if its input or its test bit is set. Only the low eight bits
 * of each register exist. Byte strobes, priority and vectoring are not
 * supported. pready rises in the second access cycle.
 */
`timescale 1ns/1ps

module irq_ctrl (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           sel,
	input  periph_pkg::apb_req_t           req,
	input  logic [periph_pkg::NR_IRQS-1:0] irq_in,
	output periph_pkg::apb_rsp_t           rsp,
	output logic                           irq_req
);

	logic [periph_pkg::NR_IRQS-1:0] enabled;
	logic [periph_pkg::NR_IRQS-1:0] test;
	logic [periph_pkg::NR_IRQS-1:0] status;
	logic                           ready;
	logic                           access;
	logic                           wr_en;
	logic [1:0]                     reg_idx;
	logic [periph_pkg::DATA_W-1:0]  rd_data;

	assign access = sel && req.penable;
	assign reg_idx = req.paddr[3:2];

	// Writes land on the edge that completes the transfer
	assign wr_en = access && ready && req.pwrite;

	assign status = (irq_in | test) & enabled;
	assign irq_req = |status;

	// One wait state, then a single-cycle acknowledge
	always_ff @(posedge clk) begin
		if (rst) begin
			ready <= 1'b0;
		end else begin
			ready <= access && !ready;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			enabled <= '0;
			test <= '0;
		end else if (wr_en) begin
			case (reg_idx)
				periph_pkg::IRQ_ENABLE: begin
					enabled <= enabled | req.pwdata[periph_pkg::NR_IRQS-1:0];
				end
				periph_pkg::IRQ_DISABLE: begin
					enabled <= enabled & ~req.pwdata[periph_pkg::NR_IRQS-1:0];
				end
				periph_pkg::IRQ_TEST: begin
					test <= req.pwdata[periph_pkg::NR_IRQS-1:0];
				end
				// The status register is read-only
				default: begin
				end
			endcase
		end
	end

	always_comb begin
		rd_data = '0;
		case (reg_idx)
			periph_pkg::IRQ_STATUS: rd_data[periph_pkg::NR_IRQS-1:0] = status;
			periph_pkg::IRQ_ENABLE: rd_data[periph_pkg::NR_IRQS-1:0] = enabled;
			periph_pkg::IRQ_TEST: rd_data[periph_pkg::NR_IRQS-1:0] = test;
			// Disable is write-only and reads as zero
			default: rd_data = '0;
		endcase
	end

	assign rsp = '{
		prdata: ready ? rd_data : '0,
		pready: ready,
		pslverr: 1'b0
	};

	// The acknowledge falls in the second cycle of an access phase that
	// the master still holds
	a_ready_after_access: assert property (
		@(posedge clk) disable iff (rst)
		rsp.pready |-> access && $past(access)
	) else $error("pready outside a held two-cycle access phase");

endmodule

// File: hdl/interval_timer.sv
/*
 * Reloading down-counter with a sticky expiry flag.
 * Writing the load register also loads the count. While enabled the count
 * steps down once per clock; the step from one to zero sets the flag, and
 * a zero count reloads. A reload value of zero therefore never expires.
 * An expiry in the same cycle as a flag clear wins over the clear.
 */
`timescale 1ns/1ps

module interval_timer (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 sel,
	input  periph_pkg::apb_req_t req,
	output periph_pkg::apb_rsp_t rsp,
	output logic                 timer_irq
);

	logic                          enable;
	logic [periph_pkg::DATA_W-1:0] load_val;
	logic [periph_pkg::DATA_W-1:0] count;
	logic                          expired;
	logic                          ready;
	logic                          access;
	logic                          wr_en;
	logic [1:0]                    reg_idx;
	logic [periph_pkg::DATA_W-1:0] rd_data;

	assign access = sel && req.penable;
	assign reg_idx = req.paddr[3:2];
	assign wr_en = access && ready && req.pwrite;
	assign timer_irq = expired;

	// Same handshake as the interrupt controller
	always_ff @(posedge clk) begin
		if (rst) begin
			ready <= 1'b0;
		end else begin
			ready <= access && !ready;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			enable <= 1'b0;
			load_val <= '0;
			count <= '0;
			expired <= 1'b0;
		end else begin
			if (enable) begin
				if (count == '0) begin
					count <= load_val;
				end else begin
					count <= count - 1;
				end
			end

			if (wr_en) begin
				case (reg_idx)
					periph_pkg::TMR_CTRL: enable <= req.pwdata[0];
					periph_pkg::TMR_LOAD: begin
						load_val <= req.pwdata;
						count <= req.pwdata;
					end
					periph_pkg::TMR_EXPIRED: begin
						if (req.pwdata[0])
							expired <= 1'b0;
					end
					// The count register is read-only
					default: begin
					end
				endcase
			end

			// Placed last so a new expiry is never lost to a clear
			if (enable && count == 1)
				expired <= 1'b1;
		end
	end

	always_comb begin
		rd_data = '0;
		case (reg_idx)
			periph_pkg::TMR_CTRL: rd_data[0] = enable;
			periph_pkg::TMR_LOAD: rd_data = load_val;
			periph_pkg::TMR_COUNT: rd_data = count;
			periph_pkg::TMR_EXPIRED: rd_data[0] = expired;
		endcase
	end

	assign rsp = '{
		prdata: ready ? rd_data : '0,
		pready: ready,
		pslverr: 1'b0
	};

	// Load and count start equal at reset and on every load write, and the
	// count only moves down or reloads from there
	a_count_bounded: assert property (
		@(posedge clk) disable iff (rst)
		count <= load_val
	) else $error("timer count %0d above load value %0d", count, load_val);

endmodule

// File: hdl/periph_top.sv
/*
 * APB peripheral subsystem with an interrupt controller and an
 * interval timer behind one address decoder.
 * The timer expiry is interrupt source 7; irq_in feeds sources 0 to 6.
 * Mapped transfers take three cycles from setup to completion.
 */
`timescale 1ns/1ps

module periph_top (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               psel,
	input  periph_pkg::apb_req_t               req,
	input  logic [periph_pkg::NR_EXT_IRQS-1:0] irq_in,
	output periph_pkg::apb_rsp_t               rsp,
	output logic                               irq_req
);

	logic                           irq_sel;
	logic                           timer_sel;
	periph_pkg::apb_rsp_t           irq_rsp;
	periph_pkg::apb_rsp_t           timer_rsp;
	logic                           timer_irq;
	logic [periph_pkg::NR_IRQS-1:0] irq_src;

	// External lines fill the low sources, the timer takes its own slot
	always_comb begin
		irq_src = periph_pkg::NR_IRQS'(irq_in);
		irq_src[periph_pkg::TMR_IRQ_SRC] = timer_irq;
	end

	apb_fabric fabric (
		.psel(psel),
		.req(req),
		.irq_rsp(irq_rsp),
		.timer_rsp(timer_rsp),
		.irq_sel(irq_sel),
		.timer_sel(timer_sel),
		.rsp(rsp)
	);

	irq_ctrl irq (
		.clk(clk),
		.rst(rst),
		.sel(irq_sel),
		.req(req),
		.irq_in(irq_src),
		.rsp(irq_rsp),
		.irq_req(irq_req)
	);

	interval_timer timer (
		.clk(clk),
		.rst(rst),
		.sel(timer_sel),
		.req(req),
		.rsp(timer_rsp),
		.timer_irq(timer_irq)
	);

endmodule

// File: testbench/tb_checks.svh
/*
 * APB master tasks and typed compare tasks for the peripheral testbench.
 * Included inside tb_periph, so the tasks drive and sample its signals.
 * Inputs change on the falling edge. Outputs are sampled one step after it.
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Called on a falling edge; returns on the falling edge after the bus goes idle
task automatic apb_transfer(
	input  logic [periph_pkg::ADDR_W-1:0] addr,
	input  logic                          write,
	input  logic [periph_pkg::DATA_W-1:0] data,
	output periph_pkg::apb_rsp_t          got
);
	int waits;

	psel = 1'b1;
	req = '{paddr: addr, pwrite: write, pwdata: data, penable: 1'b0};
	@(negedge clk);
	req.penable = 1'b1;
	waits = 0;
	#SAMPLE_DLY;
	while (!rsp.pready && waits < READY_LIMIT) begin
		@(negedge clk);
		#SAMPLE_DLY;
		waits++;
	end
	if (!rsp.pready) begin
		abort_run($sformatf("no pready within %0d cycles at address %h",
			READY_LIMIT, addr));
	end else begin
		got = rsp;
		// The transfer completes on this edge
		@(posedge clk);
		@(negedge clk);
		psel = 1'b0;
		req.penable = 1'b0;
	end
endtask

task automatic apb_write(
	input  logic [periph_pkg::ADDR_W-1:0] addr,
	input  logic [periph_pkg::DATA_W-1:0] data,
	output periph_pkg::apb_rsp_t          got
);
	apb_transfer(addr, 1'b1, data, got);
endtask

task automatic apb_read(
	input  logic [periph_pkg::ADDR_W-1:0] addr,
	output periph_pkg::apb_rsp_t          got
);
	apb_transfer(addr, 1'b0, '0, got);
endtask

// All response fields on one line for error messages
function automatic string format_rsp(input periph_pkg::apb_rsp_t r);
	return $sformatf("prdata=%h pready=%b pslverr=%b", r.prdata, r.pready, r.pslverr);
endfunction

task automatic check_rsp(
	input string                name,
	input periph_pkg::apb_rsp_t want,
	input periph_pkg::apb_rsp_t got
);
	if (got !== want) begin
		$display("FAILED %s: expected %s, actual %s",
			name, format_rsp(want), format_rsp(got));
		abort_run($sformatf("response mismatch in %s", name));
	end
endtask

task automatic check_irq(input string name, input logic want, input logic got);
	if (got !== want) begin
		$display("FAILED %s: expected irq_req=%b, actual irq_req=%b", name, want, got);
		abort_run($sformatf("irq_req mismatch in %s", name));
	end
endtask

`endif

// File: testbench/tb_periph.sv
/*
 * Testbench for the APB peripheral subsystem.
 * Vectors come from testbench/periph_stim.txt, so the simulation must be
 * started from the project root. The run stops at the first mismatch.
 */
`timescale 1ns/1ps

module tb_periph;

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int SAMPLE_DLY = 1;
	localparam int READY_LIMIT = 4;
	localparam int POLL_LIMIT = 100;
	localparam int CYCLES_PER_LINE = 40;
	localparam int POLL_CYCLES = 2000;

	typedef struct packed {
		logic [periph_pkg::ADDR_W-1:0]      addr;
		logic [periph_pkg::DATA_W-1:0]      wdata;
		logic [periph_pkg::NR_EXT_IRQS-1:0] irq;
		logic [periph_pkg::DATA_W-1:0]      exp_data;
		logic                               exp_irq;
	} vector_t;

	logic                               clk = 1'b0;
	logic                               rst;
	logic                               psel;
	periph_pkg::apb_req_t               req;
	logic [periph_pkg::NR_EXT_IRQS-1:0] irq_in;
	periph_pkg::apb_rsp_t               rsp;
	logic                               irq_req;

	string   names[$];
	string   ops[$];
	vector_t vecs[$];
	bit      vectors_loaded = 1'b0;

	periph_top uut (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.req(req),
		.irq_in(irq_in),
		.rsp(rsp),
		.irq_req(irq_req)
	);

	always #HALF_PERIOD clk = ~clk;

	task automatic abort_run(input string why);
		$display("Done: errors found");
		$fatal(1, "%s", why);
	endtask

	`include "tb_checks.svh"

	function automatic bit known_op(input string op);
		return op == "write" || op == "read" || op == "errread" ||
			op == "errwrite" || op == "setirq" || op == "poll";
	endfunction

	task automatic load_vectors();
		int                                 fd;
		int                                 n;
		string                              line;
		string                              name;
		string                              op;
		logic [periph_pkg::ADDR_W-1:0]      addr;
		logic [periph_pkg::DATA_W-1:0]      wdata;
		logic [periph_pkg::NR_EXT_IRQS-1:0] irq;
		logic [periph_pkg::DATA_W-1:0]      exp_data;
		logic                               exp_irq;

		fd = $fopen("testbench/periph_stim.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open testbench/periph_stim.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				// Comment lines and blank lines carry no vector
				if (line.len() < 2 || line.getc(0) == "#") begin
					continue;
				end
				n = $sscanf(line, "%s %s %h %h %h %h %b",
					name, op, addr, wdata, irq, exp_data, exp_irq);
				if (n != 7) begin
					abort_run($sformatf("malformed stimulus line: %s", line));
				end else if (!known_op(op)) begin
					abort_run($sformatf("unknown operation %s in stimulus line %s", op, name));
				end else begin
					names.push_back(name);
					ops.push_back(op);
					vecs.push_back('{addr, wdata, irq, exp_data, exp_irq});
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_vector(input string name, input string op, input vector_t v);
		periph_pkg::apb_rsp_t got;
		periph_pkg::apb_rsp_t want;
		int                   polls;

		@(negedge clk);
		irq_in = v.irq;
		want = '{prdata: v.exp_data, pready: 1'b1, pslverr: 1'b0};
		case (op)
			"write": begin
				apb_write(v.addr, v.wdata, got);
				// Read data during a write carries no meaning
				want.prdata = '0;
				got.prdata = '0;
				check_rsp(name, want, got);
			end
			"read": begin
				apb_read(v.addr, got);
				check_rsp(name, want, got);
			end
			"errread", "errwrite": begin
				want = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};
				if (op == "errread")
					apb_read(v.addr, got);
				else
					apb_write(v.addr, v.wdata, got);
				check_rsp(name, want, got);
			end
			"poll": begin
				apb_read(v.addr, got);
				polls = 1;
				while (got.prdata !== v.exp_data && polls < POLL_LIMIT) begin
					apb_read(v.addr, got);
					polls++;
				end
				if (got.prdata !== v.exp_data)
					abort_run($sformatf("%s gave up after %0d polls", name, polls));
				else
					check_rsp(name, want, got);
			end
			// setirq only changes irq_in, which is already driven
			default: begin
			end
		endcase
		#SAMPLE_DLY;
		check_irq(name, v.exp_irq, irq_req);
	endtask

	initial begin
		rst = 1'b1;
		psel = 1'b0;
		req = '0;
		irq_in = '0;
		load_vectors();
		vectors_loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#SAMPLE_DLY;
		check_rsp("reset_rsp", '0, rsp);
		check_irq("reset_irq", 1'b0, irq_req);
		foreach (vecs[i]) begin
			run_vector(names[i], ops[i], vecs[i]);
		end
		if (vecs.size() == 0) begin
			abort_run("the stimulus file holds no vectors");
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

	// Budget per vector, plus room for the timer to count down while polled
	initial begin
		wait (vectors_loaded);
		repeat (RESET_CYCLES + CYCLES_PER_LINE * vecs.size() + POLL_CYCLES) @(posedge clk);
		abort_run("simulation timed out before the last vector finished");
	end

endmodule

// File: testbench/periph_stim.txt
# name op addr wdata irq_in expected irq_req (all hex except irq_req)
# ops: write read errread errwrite setirq poll; poll repeats reads until expected
rst_status   read     000 00000000 00 00000000 0
rst_enable   read     004 00000000 00 00000000 0
rst_disable  read     008 00000000 00 00000000 0
rst_test     read     00c 00000000 00 00000000 0
rst_ctrl     read     010 00000000 00 00000000 0
rst_load     read     014 00000000 00 00000000 0
rst_count    read     018 00000000 00 00000000 0
rst_expired  read     01c 00000000 00 00000000 0
# Enable ORs bits in, disable clears them, upper bits do not exist
en_wr_a      write    004 00000013 00 00000000 0
en_rd_a      read     004 00000000 00 00000013 0
en_wr_b      write    004 00000024 00 00000000 0
en_rd_b      read     004 00000000 00 00000037 0
dis_wr       write    008 00000011 00 00000000 0
dis_rd_en    read     004 00000000 00 00000026 0
dis_rd_dis   read     008 00000000 00 00000000 0
en_upper     write    004 ffffff00 00 00000000 0
en_rd_upper  read     004 00000000 00 00000026 0
# Masking of external lines with enable mask 0x26
ext_a_stat   read     000 00000000 01 00000000 0
ext_b_stat   read     000 00000000 06 00000006 1
ext_c_stat   read     000 00000000 59 00000000 0
mask_wr      write    004 00000008 59 00000000 1
mask_stat    read     000 00000000 59 00000008 1
mask_dis     write    008 00000008 59 00000000 0
mask_stat2   read     000 00000000 59 00000000 0
ext_on       setirq   000 00000000 24 00000000 1
ext_clear    setirq   000 00000000 00 00000000 0
# Test register and the read-only status register
test_wr      write    00c 000000f0 00 00000000 1
test_rd      read     00c 00000000 00 000000f0 1
test_stat    read     000 00000000 00 00000020 1
stat_wr      write    000 000000ff 00 00000000 1
stat_rd      read     000 00000000 00 00000020 1
stat_rd_en   read     004 00000000 00 00000026 1
test_clr     write    00c 00000000 00 00000000 0
# Timer expiry drives source 7
tmr_load     write    014 00000005 00 00000000 0
tmr_load_rd  read     014 00000000 00 00000005 0
tmr_cnt_rd   read     018 00000000 00 00000005 0
tmr_src_en   write    004 00000080 00 00000000 0
tmr_start    write    010 00000001 00 00000000 0
tmr_poll     poll     01c 00000000 00 00000001 1
tmr_stat     read     000 00000000 00 00000080 1
tmr_stop     write    010 00000000 00 00000000 1
tmr_ack      write    01c 00000001 00 00000000 0
tmr_exp_rd   read     01c 00000000 00 00000000 0
tmr_ctrl_rd  read     010 00000000 00 00000000 0
# Holes in the map answer with an error and change nothing
hole_rd_a    errread  020 00000000 00 00000000 0
hole_wr_a    errwrite 024 000000ff 00 00000000 0
hole_wr_b    errwrite ffc 000000ff 00 00000000 0
hole_rd_b    errread  100 00000000 00 00000000 0
hole_en_rd   read     004 00000000 00 000000a6 0
hole_test_rd read     00c 00000000 00 00000000 0
hole_load_rd read     014 00000000 00 00000005 0

// File: tb.f
+incdir+testbench
hdl/periph_pkg.sv
hdl/apb_fabric.sv
hdl/irq_ctrl.sv
hdl/interval_timer.sv
hdl/periph_top.sv
testbench/tb_periph.sv

// File: Makefile
# Verilator build and run for the APB peripheral subsystem testbench
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_periph
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
